//--- hw/gp_regs_pkg.sv
// Correlator register map
package gp_regs_pkg;

  typedef logic [15:0] addr_t;

  // ==============================
  // Global registers
  // ==============================
  localparam addr_t ADDR_ID         = 16'h0000;
  localparam addr_t ADDR_VERSION    = 16'h0004;
  localparam addr_t ADDR_TIC_CYCLES = 16'h0008;
  localparam addr_t ADDR_CONTROL    = 16'h000C;
  localparam addr_t ADDR_TIC_COUNT  = 16'h0010;
  localparam addr_t ADDR_STATUS     = 16'h0014;

  // ==============================
  // Capture window
  // ==============================
  localparam addr_t WIN_BASE = 16'h0100;

  // Dump offsets inside the window
  localparam logic [7:0] DUMP_SEQ   = 8'h00;
  localparam logic [7:0] I_E        = 8'h04;
  localparam logic [7:0] Q_E        = 8'h08;
  localparam logic [7:0] I_P        = 8'h0C;
  localparam logic [7:0] Q_P        = 8'h10;
  localparam logic [7:0] I_L        = 8'h14;
  localparam logic [7:0] Q_L        = 8'h18;
  localparam logic [7:0] DUMP_EPOCH = 8'h1C;

  // TIC measurement offsets inside the window
  localparam logic [7:0] MEAS_SEQ       = 8'h20;
  localparam logic [7:0] TIC_EPOCH      = 8'h24;
  localparam logic [7:0] TIC_CODE_PHASE = 8'h28;
  localparam logic [7:0] TIC_CODE_NCO   = 8'h2C;
  localparam logic [7:0] TIC_CARR_CYCLE = 8'h30;
  localparam logic [7:0] TIC_CARR_NCO   = 8'h34;

  // "GP21" in ASCII
  localparam logic [31:0] ID_VALUE      = 32'h4750_3231;
  localparam logic [31:0] VERSION_VALUE = 32'h0001_0000;

  // 0.1 s at 16.368 MHz
  localparam logic [31:0] TIC_CYCLES_RESET = 32'd1_636_800;
  localparam logic        TIC_ENABLE_RESET = 1'b1;

  localparam int STAT_TIC  = 0;
  localparam int STAT_DUMP = 1;

  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- hw/gp_meas_pkg.sv
// Sample-domain measurement types
package gp_meas_pkg;

  localparam int SEQ_W        = 32;
  localparam int EPOCH_W      = 16;
  localparam int CODE_PHASE_W = 11;
  localparam int CODE_NCO_W   = 10;
  localparam int CARR_CYCLE_W = 20;
  localparam int CARR_NCO_W   = 10;

  typedef logic [SEQ_W-1:0]   seq_t;
  typedef logic [EPOCH_W-1:0] epoch_t;

  // Taps latched on each TIC
  typedef struct packed {
    epoch_t                  epoch;
    logic [CODE_PHASE_W-1:0] code_phase;   // half chips
    logic [CODE_NCO_W-1:0]   code_nco;
    logic [CARR_CYCLE_W-1:0] carr_cycle;
    logic [CARR_NCO_W-1:0]   carr_nco;
  } tic_meas_t;

  // Minimum samp_clk cycles between two events of one kind
  localparam int MIN_EVENT_GAP = 8;

endpackage

//--- hw/gp_tic_gen.sv
// TIC pulse generator
module gp_tic_gen (
  input  logic        samp_clk,
  input  logic        samp_rstn,
  input  logic        tic_enable,
  input  logic [31:0] tic_cycles,
  output logic        tic_pulse
);

  logic        en_meta;
  logic        en_sync;
  logic [31:0] cyc_meta;
  logic [31:0] cyc_sync;
  logic [31:0] cnt;

  // Two flops suffice for the quasi-static controls
  always_ff @(posedge samp_clk) begin
    if (!samp_rstn) begin
      en_meta  <= gp_regs_pkg::TIC_ENABLE_RESET;
      en_sync  <= gp_regs_pkg::TIC_ENABLE_RESET;
      cyc_meta <= gp_regs_pkg::TIC_CYCLES_RESET;
      cyc_sync <= gp_regs_pkg::TIC_CYCLES_RESET;
    end else begin
      en_meta  <= tic_enable;
      en_sync  <= en_meta;
      cyc_meta <= tic_cycles;
      cyc_sync <= cyc_meta;
    end
  end

  // Period counter runs 0 .. P-1
  always_ff @(posedge samp_clk) begin
    if (!samp_rstn) begin
      cnt       <= '0;
      tic_pulse <= 1'b0;
    end else begin
      tic_pulse <= 1'b0;
      if (!en_sync) begin
        cnt <= '0;
      end else if (cyc_sync <= 32'd1 || cnt == cyc_sync - 32'd1) begin
        // P of 0 or 1 fires every cycle
        tic_pulse <= 1'b1;
        cnt       <= '0;
      end else begin
        cnt <= cnt + 32'd1;
      end
    end
  end

  a_single_tic: assert property (@(posedge samp_clk) disable iff (!samp_rstn)
    tic_pulse && cyc_sync > 32'd1 |=> !tic_pulse || cyc_sync <= 32'd1);

endmodule

//--- hw/gp_event_capture.sv
// Sample to AXI event capture
module gp_event_capture #(
  parameter type payload_t = logic
) (
  input  logic              samp_clk,
  input  logic              samp_rstn,
  input  logic              samp_event,
  input  payload_t          payload,
  input  logic              axi_clk,
  input  logic              axi_rstn,
  output logic              evt,
  output payload_t          data,
  output gp_meas_pkg::seq_t seq
);

  // ==============================
  // Sample domain
  // ==============================
  payload_t          hold_data;
  gp_meas_pkg::seq_t hold_seq;
  logic              tog;

  // Held until the next event, which is far enough away for the AXI copy
  always_ff @(posedge samp_clk) begin
    if (samp_event) begin
      hold_data <= payload;
    end
  end

  always_ff @(posedge samp_clk) begin
    if (!samp_rstn) begin
      hold_seq <= '0;
      tog      <= 1'b0;
    end else if (samp_event) begin
      hold_seq <= hold_seq + 1'b1;
      tog      <= ~tog;
    end
  end

  a_event_gap: assert property (@(posedge samp_clk) disable iff (!samp_rstn)
    samp_event |=> !samp_event [* gp_meas_pkg::MIN_EVENT_GAP - 1]);

  // ==============================
  // AXI domain
  // ==============================
  logic tog_meta;
  logic tog_sync;
  logic tog_last;
  logic tog_edge;

  assign tog_edge = tog_sync ^ tog_last;

  always_ff @(posedge axi_clk) begin
    if (!axi_rstn) begin
      tog_meta <= 1'b0;
      tog_sync <= 1'b0;
      tog_last <= 1'b0;
      evt      <= 1'b0;
    end else begin
      tog_meta <= tog;
      tog_sync <= tog_meta;
      tog_last <= tog_sync;
      evt      <= tog_edge;
    end
  end

  // Shadow copy of the held payload and count
  always_ff @(posedge axi_clk) begin
    if (!axi_rstn) begin
      data <= '0;
      seq  <= '0;
    end else if (tog_edge) begin
      data <= hold_data;
      seq  <= hold_seq;
    end
  end

endmodule

//--- hw/gp_axil_slave.sv
// AXI-lite slave port
module gp_axil_slave (
  input  logic               axi_clk,
  input  logic               axi_rstn,
  input  logic [31:0]        s_axi_awaddr,
  input  logic               s_axi_awvalid,
  output logic               s_axi_awready,
  input  logic [31:0]        s_axi_wdata,
  input  logic [3:0]         s_axi_wstrb,
  input  logic               s_axi_wvalid,
  output logic               s_axi_wready,
  output logic [1:0]         s_axi_bresp,
  output logic               s_axi_bvalid,
  input  logic               s_axi_bready,
  input  logic [31:0]        s_axi_araddr,
  input  logic               s_axi_arvalid,
  output logic               s_axi_arready,
  output logic [31:0]        s_axi_rdata,
  output logic [1:0]         s_axi_rresp,
  output logic               s_axi_rvalid,
  input  logic               s_axi_rready,
  output logic               wr_en,
  output gp_regs_pkg::addr_t wr_addr,
  output logic [31:0]        wr_data,
  output logic [3:0]         wr_strb,
  output logic               rd_en,
  output gp_regs_pkg::addr_t rd_addr,
  input  logic [31:0]        rd_data
);

  logic        have_aw;
  logic        have_w;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;

  // ==============================
  // Write path
  // ==============================
  assign s_axi_awready = !have_aw && !s_axi_bvalid;
  assign s_axi_wready  = !have_w && !s_axi_bvalid;
  assign s_axi_bresp   = gp_regs_pkg::RESP_OKAY;

  // W data arriving before its address is parked in wdata_q
  assign wr_en   = have_aw && (have_w || s_axi_wvalid) && !s_axi_bvalid;
  assign wr_data = have_w ? wdata_q : s_axi_wdata;
  assign wr_strb = have_w ? wstrb_q : s_axi_wstrb;

  always_ff @(posedge axi_clk) begin
    if (s_axi_awvalid && s_axi_awready) begin
      wr_addr <= s_axi_awaddr[15:0];
    end
    if (s_axi_wvalid && s_axi_wready && !wr_en) begin
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_rstn) begin
      have_aw      <= 1'b0;
      have_w       <= 1'b0;
      s_axi_bvalid <= 1'b0;
    end else if (wr_en) begin
      have_aw      <= 1'b0;
      have_w       <= 1'b0;
      s_axi_bvalid <= 1'b1;
    end else begin
      if (s_axi_awvalid && s_axi_awready) begin
        have_aw <= 1'b1;
      end
      if (s_axi_wvalid && s_axi_wready) begin
        have_w <= 1'b1;
      end
      if (s_axi_bvalid && s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // ==============================
  // Read path
  // ==============================
  assign s_axi_arready = !s_axi_rvalid;
  assign s_axi_rresp   = gp_regs_pkg::RESP_OKAY;
  assign rd_en         = s_axi_arvalid && s_axi_arready;
  assign rd_addr       = s_axi_araddr[15:0];

  always_ff @(posedge axi_clk) begin
    if (rd_en) begin
      s_axi_rdata <= rd_data;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_rstn) begin
      s_axi_rvalid <= 1'b0;
    end else if (rd_en) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  a_bvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_rstn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  a_rdata_stable: assert property (@(posedge axi_clk) disable iff (!axi_rstn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

//--- hw/gp_reg_file.sv
// Correlator register file
module gp_reg_file #(
  parameter int  ACC_W  = 18,
  parameter type dump_t = logic [6*ACC_W+15:0]
) (
  input  logic                   axi_clk,
  input  logic                   axi_rstn,
  input  logic                   wr_en,
  input  gp_regs_pkg::addr_t     wr_addr,
  input  logic [31:0]            wr_data,
  input  logic [3:0]             wr_strb,
  input  logic                   rd_en,
  input  gp_regs_pkg::addr_t     rd_addr,
  output logic [31:0]            rd_data,
  output logic                   tic_enable,
  output logic [31:0]            tic_cycles,
  input  logic                   dump_evt,
  input  dump_t                  dump_data,
  input  gp_meas_pkg::seq_t      dump_seq,
  input  logic                   meas_evt,
  input  gp_meas_pkg::tic_meas_t meas_data,
  input  gp_meas_pkg::seq_t      meas_seq
);

  logic [31:0] tic_count;
  logic        stat_tic;
  logic        stat_dump;
  logic        clr_tic;
  logic        clr_dump;
  logic        in_win;
  logic [7:0]  win_off;

  function automatic logic [31:0] sext(input logic [ACC_W-1:0] v);
    return {{(32-ACC_W){v[ACC_W-1]}}, v};
  endfunction

  // ==============================
  // Write decode
  // ==============================
  always_ff @(posedge axi_clk) begin
    if (!axi_rstn) begin
      tic_cycles <= gp_regs_pkg::TIC_CYCLES_RESET;
      tic_enable <= gp_regs_pkg::TIC_ENABLE_RESET;
      clr_tic    <= 1'b0;
      clr_dump   <= 1'b0;
    end else begin
      clr_tic  <= 1'b0;
      clr_dump <= 1'b0;
      if (wr_en) begin
        case (wr_addr)
          gp_regs_pkg::ADDR_TIC_CYCLES: begin
            for (int b = 0; b < 4; b++) begin
              if (wr_strb[b]) tic_cycles[8*b +: 8] <= wr_data[8*b +: 8];
            end
          end
          gp_regs_pkg::ADDR_CONTROL: begin
            if (wr_strb[0]) tic_enable <= wr_data[0];
          end
          // Write one to clear, applied on the next cycle
          gp_regs_pkg::ADDR_STATUS: begin
            if (wr_strb[0]) begin
              clr_tic  <= wr_data[gp_regs_pkg::STAT_TIC];
              clr_dump <= wr_data[gp_regs_pkg::STAT_DUMP];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // TIC count and sticky bits, a new event beats a pending clear
  always_ff @(posedge axi_clk) begin
    if (!axi_rstn) begin
      tic_count <= '0;
      stat_tic  <= 1'b0;
      stat_dump <= 1'b0;
    end else begin
      if (meas_evt) tic_count <= tic_count + 32'd1;
      if (meas_evt) stat_tic <= 1'b1;
      else if (clr_tic) stat_tic <= 1'b0;
      if (dump_evt) stat_dump <= 1'b1;
      else if (clr_dump) stat_dump <= 1'b0;
    end
  end

  // ==============================
  // Read multiplexer
  // ==============================
  assign in_win  = (rd_addr & 16'hFF00) == gp_regs_pkg::WIN_BASE;
  assign win_off = rd_addr[7:0];

  always_comb begin
    rd_data = '0;
    if (rd_en && in_win) begin
      case (win_off)
        gp_regs_pkg::DUMP_SEQ:       rd_data = dump_seq;
        gp_regs_pkg::I_E:            rd_data = sext(dump_data.i_e);
        gp_regs_pkg::Q_E:            rd_data = sext(dump_data.q_e);
        gp_regs_pkg::I_P:            rd_data = sext(dump_data.i_p);
        gp_regs_pkg::Q_P:            rd_data = sext(dump_data.q_p);
        gp_regs_pkg::I_L:            rd_data = sext(dump_data.i_l);
        gp_regs_pkg::Q_L:            rd_data = sext(dump_data.q_l);
        gp_regs_pkg::DUMP_EPOCH:     rd_data = 32'(dump_data.epoch);
        gp_regs_pkg::MEAS_SEQ:       rd_data = meas_seq;
        gp_regs_pkg::TIC_EPOCH:      rd_data = 32'(meas_data.epoch);
        gp_regs_pkg::TIC_CODE_PHASE: rd_data = 32'(meas_data.code_phase);
        gp_regs_pkg::TIC_CODE_NCO:   rd_data = 32'(meas_data.code_nco);
        gp_regs_pkg::TIC_CARR_CYCLE: rd_data = 32'(meas_data.carr_cycle);
        gp_regs_pkg::TIC_CARR_NCO:   rd_data = 32'(meas_data.carr_nco);
        default:                     rd_data = '0;
      endcase
    end else if (rd_en) begin
      case (rd_addr)
        gp_regs_pkg::ADDR_ID:         rd_data = gp_regs_pkg::ID_VALUE;
        gp_regs_pkg::ADDR_VERSION:    rd_data = gp_regs_pkg::VERSION_VALUE;
        gp_regs_pkg::ADDR_TIC_CYCLES: rd_data = tic_cycles;
        gp_regs_pkg::ADDR_CONTROL:    rd_data = 32'(tic_enable);
        gp_regs_pkg::ADDR_TIC_COUNT:  rd_data = tic_count;
        gp_regs_pkg::ADDR_STATUS: begin
          rd_data[gp_regs_pkg::STAT_TIC]  = stat_tic;
          rd_data[gp_regs_pkg::STAT_DUMP] = stat_dump;
        end
        default:                      rd_data = '0;
      endcase
    end
  end

endmodule

//--- hw/gp_baseband_regs.sv
// Correlator host register block
module gp_baseband_regs #(
  parameter int ACC_W = 18
) (
  input  logic                                 axi_clk,
  input  logic                                 axi_rstn,
  input  logic                                 samp_clk,
  input  logic                                 samp_rstn,
  input  logic [31:0]                          s_axi_awaddr,
  input  logic                                 s_axi_awvalid,
  output logic                                 s_axi_awready,
  input  logic [31:0]                          s_axi_wdata,
  input  logic [3:0]                           s_axi_wstrb,
  input  logic                                 s_axi_wvalid,
  output logic                                 s_axi_wready,
  output logic [1:0]                           s_axi_bresp,
  output logic                                 s_axi_bvalid,
  input  logic                                 s_axi_bready,
  input  logic [31:0]                          s_axi_araddr,
  input  logic                                 s_axi_arvalid,
  output logic                                 s_axi_arready,
  output logic [31:0]                          s_axi_rdata,
  output logic [1:0]                           s_axi_rresp,
  output logic                                 s_axi_rvalid,
  input  logic                                 s_axi_rready,
  input  logic                                 dump_pulse,
  input  logic signed [ACC_W-1:0]              i_early,
  input  logic signed [ACC_W-1:0]              q_early,
  input  logic signed [ACC_W-1:0]              i_prompt,
  input  logic signed [ACC_W-1:0]              q_prompt,
  input  logic signed [ACC_W-1:0]              i_late,
  input  logic signed [ACC_W-1:0]              q_late,
  input  gp_meas_pkg::epoch_t                  epoch_dump,
  input  gp_meas_pkg::epoch_t                  tic_epoch,
  input  logic [gp_meas_pkg::CODE_PHASE_W-1:0] tic_code_phase,
  input  logic [gp_meas_pkg::CODE_NCO_W-1:0]   tic_code_nco,
  input  logic [gp_meas_pkg::CARR_CYCLE_W-1:0] tic_carr_cycle,
  input  logic [gp_meas_pkg::CARR_NCO_W-1:0]   tic_carr_nco,
  output logic                                 tic_pulse
);

  typedef struct packed {
    logic signed [ACC_W-1:0] i_e;
    logic signed [ACC_W-1:0] q_e;
    logic signed [ACC_W-1:0] i_p;
    logic signed [ACC_W-1:0] q_p;
    logic signed [ACC_W-1:0] i_l;
    logic signed [ACC_W-1:0] q_l;
    gp_meas_pkg::epoch_t     epoch;
  } dump_t;

  logic                   wr_en;
  gp_regs_pkg::addr_t     wr_addr;
  logic [31:0]            wr_data;
  logic [3:0]             wr_strb;
  logic                   rd_en;
  gp_regs_pkg::addr_t     rd_addr;
  logic [31:0]            rd_data;
  logic                   tic_enable;
  logic [31:0]            tic_cycles;
  dump_t                  dump_in;
  logic                   dump_evt;
  dump_t                  dump_data;
  gp_meas_pkg::seq_t      dump_seq;
  gp_meas_pkg::tic_meas_t meas_in;
  logic                   meas_evt;
  gp_meas_pkg::tic_meas_t meas_data;
  gp_meas_pkg::seq_t      meas_seq;

  // Sample-domain payloads
  assign dump_in = '{i_e: i_early, q_e: q_early, i_p: i_prompt, q_p: q_prompt,
                     i_l: i_late, q_l: q_late, epoch: epoch_dump};
  assign meas_in = '{epoch: tic_epoch, code_phase: tic_code_phase, code_nco: tic_code_nco,
                     carr_cycle: tic_carr_cycle, carr_nco: tic_carr_nco};

  gp_axil_slave i_axil (.*);

  gp_reg_file #(
    .ACC_W  (ACC_W),
    .dump_t (dump_t)
  ) i_regs (.*);

  gp_tic_gen i_tic (.*);

  // ==============================
  // Event hand-over
  // ==============================
  gp_event_capture #(.payload_t(dump_t)) i_dump_cap (
    .samp_clk   (samp_clk),
    .samp_rstn  (samp_rstn),
    .samp_event (dump_pulse),
    .payload    (dump_in),
    .axi_clk    (axi_clk),
    .axi_rstn   (axi_rstn),
    .evt        (dump_evt),
    .data       (dump_data),
    .seq        (dump_seq)
  );

  gp_event_capture #(.payload_t(gp_meas_pkg::tic_meas_t)) i_meas_cap (
    .samp_clk   (samp_clk),
    .samp_rstn  (samp_rstn),
    .samp_event (tic_pulse),
    .payload    (meas_in),
    .axi_clk    (axi_clk),
    .axi_rstn   (axi_rstn),
    .evt        (meas_evt),
    .data       (meas_data),
    .seq        (meas_seq)
  );

endmodule

//--- sim/gp_tests.svh
// Directed register block tests

task automatic reset_state_test();
  logic [31:0] v;
  gp_regs_pkg::addr_t unmapped [3] = '{16'h0018, 16'h0138, 16'h0200};
  axi_read(gp_regs_pkg::ADDR_ID, v);
  expect_value(v, "GP21", "ID");
  axi_read(gp_regs_pkg::ADDR_VERSION, v);
  expect_value(v, 32'h0001_0000, "VERSION");
  axi_read(gp_regs_pkg::ADDR_TIC_CYCLES, v);
  expect_value(v, 32'd1_636_800, "TIC_CYCLES after reset");
  axi_read(gp_regs_pkg::ADDR_CONTROL, v);
  expect_value(v, 32'd1, "CONTROL after reset");
  axi_read(gp_regs_pkg::ADDR_TIC_COUNT, v);
  expect_value(v, 32'd0, "TIC_COUNT after reset");
  foreach (unmapped[k]) begin
    axi_read(unmapped[k], v);
    expect_value(v, 32'd0, $sformatf("unmapped offset %h", unmapped[k]));
  end
  // ID is read-only
  axi_write(gp_regs_pkg::ADDR_ID, 32'hDEAD_BEEF, 4'hF);
  axi_read(gp_regs_pkg::ADDR_ID, v);
  expect_value(v, "GP21", "ID after write");
endtask

task automatic byte_strobe_test();
  logic [31:0] model;
  logic [31:0] data;
  logic [31:0] v;
  logic [3:0]  strb;
  model = 32'd1_636_800;
  // Ticking stays off so random periods never fire
  axi_write(gp_regs_pkg::ADDR_CONTROL, 32'd0, 4'h1);
  axi_read(gp_regs_pkg::ADDR_CONTROL, v);
  expect_value(v, 32'd0, "CONTROL after disable");
  for (int k = 0; k < 8; k++) begin
    data = $urandom;
    strb = 4'($urandom);
    axi_write(gp_regs_pkg::ADDR_TIC_CYCLES, data, strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) model[8*b +: 8] = data[8*b +: 8];
    end
    axi_read(gp_regs_pkg::ADDR_TIC_CYCLES, v);
    expect_value(v, model, $sformatf("TIC_CYCLES after strobe %b", strb));
  end
endtask

task automatic tic_generation_test();
  logic [31:0] count0;
  logic [31:0] seq0;
  logic [31:0] v;
  int n;
  axi_write(gp_regs_pkg::ADDR_TIC_CYCLES, 32'd20, 4'hF);
  repeat (4) @(posedge axi_clk);
  axi_read(gp_regs_pkg::ADDR_TIC_COUNT, count0);
  axi_read(win_addr(gp_regs_pkg::MEAS_SEQ), seq0);
  tic_times.delete();
  axi_write(gp_regs_pkg::ADDR_CONTROL, 32'd1, 4'h1);
  repeat (400) @(posedge samp_clk);
  axi_write(gp_regs_pkg::ADDR_CONTROL, 32'd0, 4'h1);
  // Enough for the last pulse to cross over
  repeat (10) @(posedge axi_clk);
  n = tic_times.size();
  assert (n >= 18) else
    report_failure($sformatf("Only %0d TIC pulses seen in 400 sample cycles", n));
  for (int k = 1; k < n; k++) begin
    expect_value(32'(tic_times[k] - tic_times[k-1]), 32'd20, "TIC pulse gap");
  end
  axi_read(gp_regs_pkg::ADDR_TIC_COUNT, v);
  expect_value(v, count0 + n, "TIC_COUNT");
  axi_read(win_addr(gp_regs_pkg::MEAS_SEQ), v);
  expect_value(v, seq0 + n, "MEAS_SEQ");
  axi_read(win_addr(gp_regs_pkg::TIC_EPOCH), v);
  expect_value(v, 32'(tic_epoch), "TIC epoch");
  axi_read(win_addr(gp_regs_pkg::TIC_CODE_PHASE), v);
  expect_value(v, 32'(tic_code_phase), "TIC code phase");
  axi_read(win_addr(gp_regs_pkg::TIC_CODE_NCO), v);
  expect_value(v, 32'(tic_code_nco), "TIC code NCO");
  axi_read(win_addr(gp_regs_pkg::TIC_CARR_CYCLE), v);
  expect_value(v, 32'(tic_carr_cycle), "TIC carrier cycle");
  axi_read(win_addr(gp_regs_pkg::TIC_CARR_NCO), v);
  expect_value(v, 32'(tic_carr_nco), "TIC carrier NCO");
endtask

task automatic dump_capture_test();
  logic signed [ACC_W-1:0] acc [6];
  logic [15:0] epoch;
  logic [31:0] seq0;
  logic [31:0] v;
  int exp_v;
  int tries;
  axi_read(win_addr(gp_regs_pkg::DUMP_SEQ), seq0);
  for (int d = 0; d < 4; d++) begin
    foreach (acc[k]) acc[k] = ACC_W'($urandom);
    // At least one negative accumulator per dump
    acc[d][ACC_W-1] = 1'b1;
    epoch = 16'($urandom);
    @(posedge samp_clk);
    dump_pulse <= 1'b1;
    {i_early, q_early, i_prompt} <= {acc[0], acc[1], acc[2]};
    {q_prompt, i_late, q_late} <= {acc[3], acc[4], acc[5]};
    epoch_dump <= epoch;
    @(posedge samp_clk);
    dump_pulse <= 1'b0;
    // Poll the sequence count until the dump has landed
    tries = 0;
    do begin
      axi_read(win_addr(gp_regs_pkg::DUMP_SEQ), v);
      tries++;
    end while (v != seq0 + d + 1 && tries < 10);
    expect_value(v, seq0 + d + 1, "DUMP_SEQ");
    foreach (acc[k]) begin
      exp_v = acc[k];
      axi_read(win_addr(gp_regs_pkg::I_E + 8'(4 * k)), v);
      expect_value(v, 32'(exp_v), $sformatf("accumulator %0d of dump %0d", k, d));
    end
    axi_read(win_addr(gp_regs_pkg::DUMP_EPOCH), v);
    expect_value(v, {16'h0000, epoch}, "dump epoch");
  end
endtask

task automatic sticky_status_test();
  logic [31:0] v;
  axi_read(gp_regs_pkg::ADDR_STATUS, v);
  expect_value(v, 32'h3, "STATUS after events");
  axi_write(gp_regs_pkg::ADDR_STATUS, 32'h1, 4'h1);
  axi_read(gp_regs_pkg::ADDR_STATUS, v);
  expect_value(v, 32'h2, "STATUS after TIC clear");
  axi_write(gp_regs_pkg::ADDR_STATUS, 32'h2, 4'h1);
  axi_read(gp_regs_pkg::ADDR_STATUS, v);
  expect_value(v, 32'h0, "STATUS after dump clear");
endtask

task automatic back_pressure_test();
  logic [31:0] held;
  logic [31:0] v;
  int cyc;
  // Write held in its response phase
  @(posedge axi_clk);
  s_axi_awaddr  <= {16'h0000, gp_regs_pkg::ADDR_TIC_CYCLES};
  s_axi_awvalid <= 1'b1;
  s_axi_wdata   <= 32'h0000_1234;
  s_axi_wstrb   <= 4'hF;
  s_axi_wvalid  <= 1'b1;
  s_axi_bready  <= 1'b0;
  cyc = 0;
  do begin
    @(posedge axi_clk);
    cyc++;
    if (s_axi_awvalid && s_axi_awready) s_axi_awvalid <= 1'b0;
    if (s_axi_wvalid && s_axi_wready) s_axi_wvalid <= 1'b0;
  end while (!s_axi_bvalid && cyc < BUS_TIMEOUT);
  assert (s_axi_bvalid) else report_failure("AXI write never raised bvalid");
  repeat (5) begin
    @(posedge axi_clk);
    expect_value(32'(s_axi_awready), 32'd0, "awready while bvalid is held");
    expect_value(32'(s_axi_wready), 32'd0, "wready while bvalid is held");
    expect_value(32'(s_axi_bvalid), 32'd1, "bvalid while bready is low");
  end
  s_axi_bready <= 1'b1;
  @(posedge axi_clk);
  s_axi_bready <= 1'b0;
  @(posedge axi_clk);
  expect_value(32'(s_axi_bvalid), 32'd0, "bvalid after bready returned");
  expect_value(32'(s_axi_awready), 32'd1, "awready after the write completed");
  expect_value(32'(s_axi_wready), 32'd1, "wready after the write completed");
  axi_read(gp_regs_pkg::ADDR_TIC_CYCLES, v);
  expect_value(v, 32'h0000_1234, "TIC_CYCLES after stalled write");
  // Read held in its data phase
  @(posedge axi_clk);
  s_axi_araddr  <= {16'h0000, gp_regs_pkg::ADDR_ID};
  s_axi_arvalid <= 1'b1;
  s_axi_rready  <= 1'b0;
  cyc = 0;
  do begin
    @(posedge axi_clk);
    cyc++;
    if (s_axi_arvalid && s_axi_arready) s_axi_arvalid <= 1'b0;
  end while (!s_axi_rvalid && cyc < BUS_TIMEOUT);
  assert (s_axi_rvalid) else report_failure("AXI read never raised rvalid");
  held = s_axi_rdata;
  repeat (5) begin
    @(posedge axi_clk);
    expect_value(32'(s_axi_arready), 32'd0, "arready while rvalid is held");
    expect_value(32'(s_axi_rvalid), 32'd1, "rvalid while rready is low");
    expect_value(s_axi_rdata, held, "rdata while rready is low");
  end
  s_axi_rready <= 1'b1;
  @(posedge axi_clk);
  s_axi_rready <= 1'b0;
  @(posedge axi_clk);
  expect_value(32'(s_axi_rvalid), 32'd0, "rvalid after rready returned");
  expect_value(32'(s_axi_arready), 32'd1, "arready after the read completed");
  expect_value(held, "GP21", "ID from stalled read");
  axi_read(gp_regs_pkg::ADDR_VERSION, v);
  expect_value(v, 32'h0001_0000, "VERSION after stalled read");
endtask

//--- sim/tb_gp_baseband_regs.sv
// Correlator register block testbench
module tb_gp_baseband_regs;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          ACC_W       = 18;
  localparam int          SAMP_PERIOD = 6;
  localparam int          BUS_TIMEOUT = 20;
  localparam logic [31:0] SEED        = 32'h6e44_e08a;

  // Rough length of each test in ns
  localparam int RESET_NS    = 1000;
  localparam int STROBE_NS   = 1500;
  localparam int TIC_NS      = 4000;
  localparam int DUMP_NS     = 3500;
  localparam int STATUS_NS   = 500;
  localparam int PRESSURE_NS = 800;
  localparam int WATCHDOG_NS = 2 * (RESET_NS + STROBE_NS + TIC_NS + DUMP_NS + STATUS_NS
                                    + PRESSURE_NS);

  logic axi_clk = 1'b0;
  logic samp_clk = 1'b0;
  logic axi_rstn, samp_rstn;
  logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
  logic [3:0] s_axi_wstrb;
  logic [1:0] s_axi_bresp, s_axi_rresp;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic s_axi_rvalid, s_axi_rready;
  logic dump_pulse, tic_pulse;
  logic signed [ACC_W-1:0] i_early, q_early, i_prompt, q_prompt, i_late, q_late;
  logic [15:0] epoch_dump, tic_epoch;
  logic [10:0] tic_code_phase;
  logic [9:0] tic_code_nco, tic_carr_nco;
  logic [19:0] tic_carr_cycle;

  // Sample cycle stamps of every TIC pulse
  longint unsigned samp_cyc = 0;
  longint unsigned tic_times [$];

  always #5 axi_clk = ~axi_clk;
  always #(SAMP_PERIOD / 2) samp_clk = ~samp_clk;

  always @(posedge samp_clk) samp_cyc <= samp_cyc + 1;

  always @(negedge samp_clk) begin
    if (tic_pulse) tic_times.push_back(samp_cyc);
  end

  gp_baseband_regs #(.ACC_W(ACC_W)) i_dut (.*);

  // ==============================
  // Checking and bus helpers
  // ==============================
  task automatic report_failure(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    assert (got === exp) else
      report_failure($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  function automatic gp_regs_pkg::addr_t win_addr(input logic [7:0] off);
    return gp_regs_pkg::WIN_BASE + 16'(off);
  endfunction

  task automatic axi_write(input gp_regs_pkg::addr_t addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int cyc;
    bit done;
    cyc = 0;
    done = 1'b0;
    @(posedge axi_clk);
    s_axi_awaddr  <= {16'h0000, addr};
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    s_axi_bready  <= 1'b1;
    while (!done && cyc < BUS_TIMEOUT) begin
      @(posedge axi_clk);
      cyc++;
      if (s_axi_awvalid && s_axi_awready) s_axi_awvalid <= 1'b0;
      if (s_axi_wvalid && s_axi_wready) s_axi_wvalid <= 1'b0;
      if (s_axi_bvalid && s_axi_bready) begin
        done = 1'b1;
        s_axi_bready <= 1'b0;
        expect_value(32'(s_axi_bresp), 32'd0, "write response");
      end
    end
    assert (done) else report_failure($sformatf("AXI write to %h got no response", addr));
  endtask

  task automatic axi_read(input gp_regs_pkg::addr_t addr, output logic [31:0] data);
    int cyc;
    bit done;
    cyc = 0;
    done = 1'b0;
    @(posedge axi_clk);
    s_axi_araddr  <= {16'h0000, addr};
    s_axi_arvalid <= 1'b1;
    s_axi_rready  <= 1'b1;
    while (!done && cyc < BUS_TIMEOUT) begin
      @(posedge axi_clk);
      cyc++;
      if (s_axi_arvalid && s_axi_arready) s_axi_arvalid <= 1'b0;
      if (s_axi_rvalid && s_axi_rready) begin
        done = 1'b1;
        data = s_axi_rdata;
        s_axi_rready <= 1'b0;
        expect_value(32'(s_axi_rresp), 32'd0, "read response");
      end
    end
    assert (done) else report_failure($sformatf("AXI read of %h returned no data", addr));
  endtask

  `include "gp_tests.svh"

  // ==============================
  // Watchdog and test sequence
  // ==============================
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    axi_rstn = 1'b0;
    samp_rstn = 1'b0;
    {s_axi_awaddr, s_axi_awvalid, s_axi_wdata, s_axi_wstrb, s_axi_wvalid} = '0;
    {s_axi_bready, s_axi_araddr, s_axi_arvalid, s_axi_rready} = '0;
    {dump_pulse, i_early, q_early, i_prompt, q_prompt, i_late, q_late, epoch_dump} = '0;
    // Constant taps for the whole run
    tic_epoch = 16'($urandom);
    tic_code_phase = 11'($urandom);
    tic_code_nco = 10'($urandom);
    tic_carr_cycle = 20'($urandom);
    tic_carr_nco = 10'($urandom);
    fork
      begin
        repeat (3) @(posedge axi_clk);
        axi_rstn <= 1'b1;
      end
      begin
        repeat (3) @(posedge samp_clk);
        samp_rstn <= 1'b1;
      end
    join
    repeat (2) @(posedge axi_clk);
    reset_state_test();
    byte_strobe_test();
    tic_generation_test();
    dump_capture_test();
    sticky_status_test();
    back_pressure_test();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- all.f
+incdir+sim
hw/gp_regs_pkg.sv
hw/gp_meas_pkg.sv
hw/gp_tic_gen.sv
hw/gp_event_capture.sv
hw/gp_axil_slave.sv
hw/gp_reg_file.sv
hw/gp_baseband_regs.sv
sim/tb_gp_baseband_regs.sv
